// ==== datapathPkg.sv ====
// Datapath shared definitions
package datapathPkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int WORD_WIDTH       = 16;
    localparam int ADDR_WIDTH       = 10;
    localparam int MEM_DEPTH        = 256;
    localparam int MEM_ADDR_WIDTH   = $clog2(MEM_DEPTH);
    localparam int PORT_COUNT       = 4;
    localparam int PORT_INDEX_WIDTH = $clog2(PORT_COUNT);

    // ------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------
    // Bank A reads and writes start at zero
    localparam int IO_PORT_BASE_ADDR     = 256;
    localparam int MEM_WRITE_BASE_ADDR_B = 512;
    localparam int IO_WRITE_BASE_ADDR_A  = 256;
    localparam int IO_WRITE_BASE_ADDR_B  = 768;

    typedef enum logic [2:0] {
        ADD, SUB, AND, OR, XOR, PASSA, PASSB, MUL
    } aluOpT;

    typedef struct packed {
        logic                  valid;
        aluOpT                 op;
        logic [ADDR_WIDTH-1:0] readAddrA;
        logic [ADDR_WIDTH-1:0] readAddrB;
        logic [ADDR_WIDTH-1:0] writeAddrD;
    } instrT;

    typedef struct packed {
        logic [WORD_WIDTH-1:0] ra;
        logic [WORD_WIDTH-1:0] rb;
        logic                  carryOut;
        logic                  overflow;
    } aluResultT;

    typedef struct packed {
        logic readIsIoA;
        logic readIsIoB;
        logic writeIsIoA;
        logic writeIsIoB;
        logic ioReady;
    } predT;

    // Address falls inside [base, base + size)
    function automatic logic inWindow(input logic [ADDR_WIDTH-1:0] addr,
                                      input int unsigned base,
                                      input int unsigned size);
        return (addr >= base) && (addr < base + size);
    endfunction

    function automatic logic [PORT_COUNT-1:0] portOneHot(
            input logic [PORT_INDEX_WIDTH-1:0] idx);
        return PORT_COUNT'(1) << idx;
    endfunction

endpackage

// ==== ioPredication.sv ====
// I/O predication
`timescale 1ns/10ps

module ioPredication (
    input  logic                                 clock,
    input  logic                                 rstN,
    input  datapathPkg::instrT                   s1Instr,
    input  logic [datapathPkg::PORT_COUNT-1:0]   readEfA,
    input  logic [datapathPkg::PORT_COUNT-1:0]   readEfB,
    input  logic [datapathPkg::PORT_COUNT-1:0]   writeEfA,
    input  logic [datapathPkg::PORT_COUNT-1:0]   writeEfB,
    input  logic                                 cancel,
    output logic [datapathPkg::PORT_COUNT-1:0]   ioRdenA,
    output logic [datapathPkg::PORT_COUNT-1:0]   ioRdenB,
    output datapathPkg::predT                    pred,
    output logic                                 annul
);
    import datapathPkg::*;

    logic                        cancelQ;
    logic [PORT_INDEX_WIDTH-1:0] idxA;
    logic [PORT_INDEX_WIDTH-1:0] idxB;
    logic [PORT_INDEX_WIDTH-1:0] idxD;
    logic                        readIsIoA;
    logic                        readIsIoB;
    logic                        writeIsIoA;
    logic                        writeIsIoB;
    logic                        readOkA;
    logic                        readOkB;
    logic                        writeOk;
    logic                        ioReady;
    logic                        issue;

    // Cancel is sampled with the instruction, so it lines up with stage 1
    always_ff @(posedge clock) begin
        if (!rstN) begin
            cancelQ <= 1'b0;
        end else begin
            cancelQ <= cancel;
        end
    end

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    // I/O windows are aligned, so the low bits give the port
    assign idxA = s1Instr.readAddrA[PORT_INDEX_WIDTH-1:0];
    assign idxB = s1Instr.readAddrB[PORT_INDEX_WIDTH-1:0];
    assign idxD = s1Instr.writeAddrD[PORT_INDEX_WIDTH-1:0];

    assign readIsIoA  = inWindow(s1Instr.readAddrA, IO_PORT_BASE_ADDR, PORT_COUNT);
    assign readIsIoB  = inWindow(s1Instr.readAddrB, IO_PORT_BASE_ADDR, PORT_COUNT);
    assign writeIsIoA = inWindow(s1Instr.writeAddrD, IO_WRITE_BASE_ADDR_A, PORT_COUNT);
    assign writeIsIoB = inWindow(s1Instr.writeAddrD, IO_WRITE_BASE_ADDR_B, PORT_COUNT);

    // ------------------------------------------------------------
    // Flag checks
    // ------------------------------------------------------------
    // Only the ports an instruction touches are checked
    assign readOkA = !readIsIoA || readEfA[idxA];
    assign readOkB = !readIsIoB || readEfB[idxB];
    assign writeOk = (!writeIsIoA || writeEfA[idxD]) && (!writeIsIoB || writeEfB[idxD]);
    assign ioReady = readOkA && readOkB && writeOk;

    assign issue = s1Instr.valid && ioReady && !cancelQ;
    assign annul = !issue;

    assign ioRdenA = (issue && readIsIoA) ? portOneHot(idxA) : '0;
    assign ioRdenB = (issue && readIsIoB) ? portOneHot(idxB) : '0;

    always_comb begin
        pred.readIsIoA  = readIsIoA;
        pred.readIsIoB  = readIsIoB;
        pred.writeIsIoA = writeIsIoA;
        pred.writeIsIoB = writeIsIoB;
        pred.ioReady    = ioReady;
    end

endmodule

// ==== dataMemory.sv ====
// Data memory bank
`timescale 1ns/10ps

module dataMemory (
    input  logic                                 clock,
    input  logic [datapathPkg::MEM_ADDR_WIDTH-1:0] readAddr,
    output logic [datapathPkg::WORD_WIDTH-1:0]   readData,
    input  logic                                 writeEnable,
    input  logic [datapathPkg::MEM_ADDR_WIDTH-1:0] writeAddr,
    input  logic [datapathPkg::WORD_WIDTH-1:0]   writeData
);
    import datapathPkg::*;

    logic [WORD_WIDTH-1:0] mem [MEM_DEPTH];

    // ------------------------------------------------------------
    // Single write port, registered read port
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // Same-edge read of a written address returns the old word
    always_ff @(posedge clock) begin
        readData <= mem[readAddr];
    end

endmodule

// ==== operandFetch.sv ====
// Operand fetch and select
`timescale 1ns/10ps

module operandFetch (
    input  logic                                 clock,
    input  logic                                 rstN,
    input  logic [datapathPkg::ADDR_WIDTH-1:0]   readAddrA,
    input  logic [datapathPkg::ADDR_WIDTH-1:0]   readAddrB,
    input  datapathPkg::predT                    pred,
    input  logic [datapathPkg::PORT_COUNT-1:0]   ioRdenA,
    input  logic [datapathPkg::PORT_COUNT-1:0]   ioRdenB,
    input  logic [datapathPkg::PORT_COUNT-1:0][datapathPkg::WORD_WIDTH-1:0] ioReadDataA,
    input  logic [datapathPkg::PORT_COUNT-1:0][datapathPkg::WORD_WIDTH-1:0] ioReadDataB,
    input  logic [datapathPkg::WORD_WIDTH-1:0]   memDataA,
    input  logic [datapathPkg::WORD_WIDTH-1:0]   memDataB,
    output logic [datapathPkg::WORD_WIDTH-1:0]   operandA,
    output logic [datapathPkg::WORD_WIDTH-1:0]   operandB
);
    import datapathPkg::*;

    logic                  selIoA;
    logic                  selIoB;
    logic                  selMemA;
    logic                  selMemB;
    logic [WORD_WIDTH-1:0] ioWordA;
    logic [WORD_WIDTH-1:0] ioWordB;

    // ------------------------------------------------------------
    // Stage 1 to stage 2 capture
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!rstN) begin
            selIoA  <= 1'b0;
            selIoB  <= 1'b0;
            selMemA <= 1'b0;
            selMemB <= 1'b0;
        end else begin
            selIoA  <= pred.readIsIoA;
            selIoB  <= pred.readIsIoB;
            selMemA <= inWindow(readAddrA, 0, MEM_DEPTH);
            selMemB <= inWindow(readAddrB, 0, MEM_DEPTH);
        end
    end

    // Port word is only taken when the read is actually consumed
    always_ff @(posedge clock) begin
        if (|ioRdenA) begin
            ioWordA <= ioReadDataA[readAddrA[PORT_INDEX_WIDTH-1:0]];
        end
        if (|ioRdenB) begin
            ioWordB <= ioReadDataB[readAddrB[PORT_INDEX_WIDTH-1:0]];
        end
    end

    // ------------------------------------------------------------
    // Stage 2 operand select
    // ------------------------------------------------------------
    // Unmapped read addresses give zero
    always_comb begin
        operandA = selIoA ? ioWordA : (selMemA ? memDataA : '0);
        operandB = selIoB ? ioWordB : (selMemB ? memDataB : '0);
    end

endmodule

// ==== alu.sv ====
// Registered ALU
`timescale 1ns/10ps

module alu (
    input  logic                                 clock,
    input  logic                                 rstN,
    input  datapathPkg::aluOpT                   op,
    input  logic [datapathPkg::WORD_WIDTH-1:0]   operandA,
    input  logic [datapathPkg::WORD_WIDTH-1:0]   operandB,
    output datapathPkg::aluResultT               result
);
    import datapathPkg::*;

    localparam int MSB = WORD_WIDTH - 1;

    logic [WORD_WIDTH:0]     sumFull;
    logic [WORD_WIDTH:0]     diffFull;
    logic [2*WORD_WIDTH-1:0] product;
    aluResultT               nextResult;

    assign sumFull  = {1'b0, operandA} + {1'b0, operandB};
    assign diffFull = {1'b0, operandA} - {1'b0, operandB};
    assign product  = operandA * operandB;

    // ------------------------------------------------------------
    // Stage 2 compute
    // ------------------------------------------------------------
    always_comb begin
        nextResult = '0;
        case (op)
            ADD: begin
                nextResult.ra       = sumFull[MSB:0];
                nextResult.carryOut = sumFull[WORD_WIDTH];
                nextResult.overflow = (operandA[MSB] == operandB[MSB]) &&
                                      (sumFull[MSB] != operandA[MSB]);
            end
            SUB: begin
                // Carry is the inverted borrow
                nextResult.ra       = diffFull[MSB:0];
                nextResult.carryOut = ~diffFull[WORD_WIDTH];
                nextResult.overflow = (operandA[MSB] != operandB[MSB]) &&
                                      (diffFull[MSB] != operandA[MSB]);
            end
            AND:   nextResult.ra = operandA & operandB;
            OR:    nextResult.ra = operandA | operandB;
            XOR:   nextResult.ra = operandA ^ operandB;
            PASSA: nextResult.ra = operandA;
            PASSB: nextResult.ra = operandB;
            MUL: begin
                nextResult.ra = product[MSB:0];
                nextResult.rb = product[2*WORD_WIDTH-1:WORD_WIDTH];
            end
            default: nextResult = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            result <= '0;
        end else begin
            result <= nextResult;
        end
    end

endmodule

// ==== resultWriteback.sv ====
// Result writeback decode
`timescale 1ns/10ps

module resultWriteback (
    input  logic                                 clock,
    input  logic                                 rstN,
    input  logic [datapathPkg::ADDR_WIDTH-1:0]   writeAddrD,
    input  logic                                 annul,
    input  logic [datapathPkg::WORD_WIDTH-1:0]   ra,
    output logic                                 memWeA,
    output logic                                 memWeB,
    output logic [datapathPkg::MEM_ADDR_WIDTH-1:0] memWriteAddr,
    output logic [datapathPkg::WORD_WIDTH-1:0]   memWriteData,
    output logic [datapathPkg::PORT_COUNT-1:0]   ioWrenA,
    output logic [datapathPkg::PORT_COUNT-1:0]   ioWrenB,
    output logic [datapathPkg::PORT_COUNT-1:0][datapathPkg::WORD_WIDTH-1:0] ioWriteDataA,
    output logic [datapathPkg::PORT_COUNT-1:0][datapathPkg::WORD_WIDTH-1:0] ioWriteDataB
);
    import datapathPkg::*;

    logic [ADDR_WIDTH-1:0] s2WriteAddr;
    logic [ADDR_WIDTH-1:0] s3WriteAddr;
    logic                  s2Annul;
    logic                  s3Annul;
    logic                  commit;

    // ------------------------------------------------------------
    // Carry the write address to stage 3
    // ------------------------------------------------------------
    always_ff @(posedge clock) begin
        s2WriteAddr <= writeAddrD;
        s3WriteAddr <= s2WriteAddr;
        if (!rstN) begin
            s2Annul <= 1'b1;
            s3Annul <= 1'b1;
        end else begin
            s2Annul <= annul;
            s3Annul <= s2Annul;
        end
    end

    // ------------------------------------------------------------
    // Stage 3 strobes with at most one target
    // ------------------------------------------------------------
    assign commit = !s3Annul;

    assign memWeA = commit && inWindow(s3WriteAddr, 0, MEM_DEPTH);
    assign memWeB = commit && inWindow(s3WriteAddr, MEM_WRITE_BASE_ADDR_B, MEM_DEPTH);
    assign ioWrenA = (commit && inWindow(s3WriteAddr, IO_WRITE_BASE_ADDR_A, PORT_COUNT))
                   ? portOneHot(s3WriteAddr[PORT_INDEX_WIDTH-1:0]) : '0;
    assign ioWrenB = (commit && inWindow(s3WriteAddr, IO_WRITE_BASE_ADDR_B, PORT_COUNT))
                   ? portOneHot(s3WriteAddr[PORT_INDEX_WIDTH-1:0]) : '0;

    // Bank B base is aligned, so both banks share the low bits
    assign memWriteAddr = s3WriteAddr[MEM_ADDR_WIDTH-1:0];
    assign memWriteData = ra;
    assign ioWriteDataA = {PORT_COUNT{ra}};
    assign ioWriteDataB = {PORT_COUNT{ra}};

endmodule

// ==== datapath.sv ====
// Predicated datapath top
`timescale 1ns/10ps

module datapath (
    input  logic                                 clock,
    input  logic                                 rstN,
    input  datapathPkg::instrT                   instr,
    input  logic                                 branchCancel,
    input  logic [datapathPkg::PORT_COUNT-1:0]   ioReadEfA,
    input  logic [datapathPkg::PORT_COUNT-1:0]   ioReadEfB,
    input  logic [datapathPkg::PORT_COUNT-1:0]   ioWriteEfA,
    input  logic [datapathPkg::PORT_COUNT-1:0]   ioWriteEfB,
    input  logic [datapathPkg::PORT_COUNT-1:0][datapathPkg::WORD_WIDTH-1:0] ioReadDataA,
    input  logic [datapathPkg::PORT_COUNT-1:0][datapathPkg::WORD_WIDTH-1:0] ioReadDataB,
    output logic [datapathPkg::PORT_COUNT-1:0]   ioRdenA,
    output logic [datapathPkg::PORT_COUNT-1:0]   ioRdenB,
    output logic [datapathPkg::PORT_COUNT-1:0]   ioWrenA,
    output logic [datapathPkg::PORT_COUNT-1:0]   ioWrenB,
    output logic [datapathPkg::PORT_COUNT-1:0][datapathPkg::WORD_WIDTH-1:0] ioWriteDataA,
    output logic [datapathPkg::PORT_COUNT-1:0][datapathPkg::WORD_WIDTH-1:0] ioWriteDataB,
    output logic                                 ioReady,
    output datapathPkg::aluResultT               result
);
    import datapathPkg::*;

    instrT                     s1Instr;
    instrT                     s2Instr;
    predT                      pred;
    logic                      annul;
    logic [WORD_WIDTH-1:0]     memDataA;
    logic [WORD_WIDTH-1:0]     memDataB;
    logic [WORD_WIDTH-1:0]     operandA;
    logic [WORD_WIDTH-1:0]     operandB;
    logic                      memWeA;
    logic                      memWeB;
    logic [MEM_ADDR_WIDTH-1:0] memWriteAddr;
    logic [WORD_WIDTH-1:0]     memWriteData;

    // ------------------------------------------------------------
    // Instruction registers
    // ------------------------------------------------------------
    // Cleared to address zero so no I/O is decoded out of reset
    always_ff @(posedge clock) begin
        if (!rstN) begin
            s1Instr <= '0;
            s2Instr <= '0;
        end else begin
            s1Instr <= instr;
            s2Instr <= s1Instr;
        end
    end

    assign ioReady = pred.ioReady;

    ioPredication u_ioPred (
        .clock    (clock),
        .rstN     (rstN),
        .s1Instr  (s1Instr),
        .readEfA  (ioReadEfA),
        .readEfB  (ioReadEfB),
        .writeEfA (ioWriteEfA),
        .writeEfB (ioWriteEfB),
        .cancel   (branchCancel),
        .ioRdenA  (ioRdenA),
        .ioRdenB  (ioRdenB),
        .pred     (pred),
        .annul    (annul)
    );

    // ------------------------------------------------------------
    // Memory banks
    // ------------------------------------------------------------
    dataMemory u_memA (
        .clock       (clock),
        .readAddr    (s1Instr.readAddrA[MEM_ADDR_WIDTH-1:0]),
        .readData    (memDataA),
        .writeEnable (memWeA),
        .writeAddr   (memWriteAddr),
        .writeData   (memWriteData)
    );

    dataMemory u_memB (
        .clock       (clock),
        .readAddr    (s1Instr.readAddrB[MEM_ADDR_WIDTH-1:0]),
        .readData    (memDataB),
        .writeEnable (memWeB),
        .writeAddr   (memWriteAddr),
        .writeData   (memWriteData)
    );

    operandFetch u_fetch (
        .clock       (clock),
        .rstN        (rstN),
        .readAddrA   (s1Instr.readAddrA),
        .readAddrB   (s1Instr.readAddrB),
        .pred        (pred),
        .ioRdenA     (ioRdenA),
        .ioRdenB     (ioRdenB),
        .ioReadDataA (ioReadDataA),
        .ioReadDataB (ioReadDataB),
        .memDataA    (memDataA),
        .memDataB    (memDataB),
        .operandA    (operandA),
        .operandB    (operandB)
    );

    alu u_alu (
        .clock    (clock),
        .rstN     (rstN),
        .op       (s2Instr.op),
        .operandA (operandA),
        .operandB (operandB),
        .result   (result)
    );

    resultWriteback u_writeback (
        .clock        (clock),
        .rstN         (rstN),
        .writeAddrD   (s1Instr.writeAddrD),
        .annul        (annul),
        .ra           (result.ra),
        .memWeA       (memWeA),
        .memWeB       (memWeB),
        .memWriteAddr (memWriteAddr),
        .memWriteData (memWriteData),
        .ioWrenA      (ioWrenA),
        .ioWrenB      (ioWrenB),
        .ioWriteDataA (ioWriteDataA),
        .ioWriteDataB (ioWriteDataB)
    );

endmodule

// ==== datapathTb.sv ====
// Datapath testbench
`timescale 1ns/10ps

module datapathTb;
    import datapathPkg::*;

    localparam int MAX_RECORDS = 1024;
    localparam int TEST_COUNT  = 6;

    logic                                 clock = 1'b0;
    logic                                 rstN;
    instrT                                instr;
    logic                                 branchCancel;
    logic [PORT_COUNT-1:0]                ioReadEfA, ioReadEfB, ioWriteEfA, ioWriteEfB;
    logic [PORT_COUNT-1:0][WORD_WIDTH-1:0] ioReadDataA, ioReadDataB;
    logic [PORT_COUNT-1:0]                ioRdenA, ioRdenB, ioWrenA, ioWrenB;
    logic [PORT_COUNT-1:0][WORD_WIDTH-1:0] ioWriteDataA, ioWriteDataB;
    logic                                 ioReady;
    aluResultT                            result;

    // Stimulus records with one entry per issue cycle
    instrT                                 recInstr [MAX_RECORDS];
    logic                                  recCancel [MAX_RECORDS];
    int                                    recTest [MAX_RECORDS];
    logic [PORT_COUNT-1:0]                 recRefA [MAX_RECORDS], recRefB [MAX_RECORDS];
    logic [PORT_COUNT-1:0]                 recWefA [MAX_RECORDS], recWefB [MAX_RECORDS];
    logic [PORT_COUNT-1:0][WORD_WIDTH-1:0] recDataA [MAX_RECORDS], recDataB [MAX_RECORDS];
    logic                                  recReady [MAX_RECORDS], recCheckRes [MAX_RECORDS];
    logic [PORT_COUNT-1:0]                 recRdenA [MAX_RECORDS], recRdenB [MAX_RECORDS];
    logic [PORT_COUNT-1:0]                 recWrenA [MAX_RECORDS], recWrenB [MAX_RECORDS];
    aluResultT                             recRes [MAX_RECORDS];

    logic [WORD_WIDTH-1:0] shadowA [MEM_DEPTH];
    logic [WORD_WIDTH-1:0] shadowB [MEM_DEPTH];
    logic [PORT_COUNT-1:0] nextRefA = '1, nextRefB = '1, nextWefA = '1, nextWefB = '1;
    string                 testName [TEST_COUNT] = '{"reset", "memory load", "alu ops",
                                                     "read predication", "io write",
                                                     "branch cancel"};
    int                    testErrors [TEST_COUNT];
    int                    nRec = 0;
    int                    errors = 0;
    int                    checks = 0;
    int                    cycle = 0;
    int                    cycleLimit = 100000;
    integer                seed = 90148;

    datapath u_dut (.*);

    always #5 clock = ~clock;

    // Cycle limit guards against a stuck run
    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle > cycleLimit) begin
            $display("Timeout after %0d cycles, stimulus did not complete", cycle);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic aluResultT refAlu(input aluOpT op, input logic [15:0] a,
                                         input logic [15:0] b);
        aluResultT   r;
        logic [16:0] wide;
        logic [31:0] prod;
        int          sa;
        int          sb;
        int          s;
        r = '0;
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            ADD: begin
                wide = a + b;
                s = sa + sb;
                r.ra = wide[15:0];
                r.carryOut = wide[16];
                r.overflow = (s > 32767) || (s < -32768);
            end
            SUB: begin
                wide = {1'b0, a} - {1'b0, b};
                s = sa - sb;
                r.ra = wide[15:0];
                r.carryOut = (a >= b);
                r.overflow = (s > 32767) || (s < -32768);
            end
            AND:   r.ra = a & b;
            OR:    r.ra = a | b;
            XOR:   r.ra = a ^ b;
            PASSA: r.ra = a;
            PASSB: r.ra = b;
            default: begin
                prod = a * b;
                r.ra = prod[15:0];
                r.rb = prod[31:16];
            end
        endcase
        return r;
    endfunction

    // Builds one record and its expected responses
    // Stimulus keeps clear of hazards
    task automatic addInstr(input int testId, input logic valid, input aluOpT op,
                            input int a, input int b, input int d, input logic cancel);
        logic [15:0] opA;
        logic [15:0] opB;
        logic        isIoA;
        logic        isIoB;
        logic        ready;
        logic        issue;
        aluResultT   r;
        int          k;
        k = nRec;
        recInstr[k] = '{valid: valid, op: op, readAddrA: a[9:0], readAddrB: b[9:0],
                        writeAddrD: d[9:0]};
        recCancel[k] = cancel;
        recTest[k] = testId;
        recRefA[k] = nextRefA;
        recRefB[k] = nextRefB;
        recWefA[k] = nextWefA;
        recWefB[k] = nextWefB;
        recDataA[k] = {$random(seed), $random(seed)};
        recDataB[k] = {$random(seed), $random(seed)};
        isIoA = (a >= 256) && (a < 260);
        isIoB = (b >= 256) && (b < 260);
        opA = isIoA ? recDataA[k][a & 3] : ((a < 256) ? shadowA[a] : 16'h0);
        opB = isIoB ? recDataB[k][b & 3] : ((b < 256) ? shadowB[b] : 16'h0);
        ready = (!isIoA || nextRefA[a & 3]) && (!isIoB || nextRefB[b & 3]);
        if (d >= 256 && d < 260) ready = ready && nextWefA[d & 3];
        if (d >= 768 && d < 772) ready = ready && nextWefB[d & 3];
        issue = valid && ready && !cancel;
        r = refAlu(op, opA, opB);
        recReady[k] = ready;
        recCheckRes[k] = issue;
        recRes[k] = r;
        recRdenA[k] = (issue && isIoA) ? 4'(1 << (a & 3)) : 4'h0;
        recRdenB[k] = (issue && isIoB) ? 4'(1 << (b & 3)) : 4'h0;
        recWrenA[k] = (issue && d >= 256 && d < 260) ? 4'(1 << (d & 3)) : 4'h0;
        recWrenB[k] = (issue && d >= 768 && d < 772) ? 4'(1 << (d & 3)) : 4'h0;
        if (issue && d < 256) shadowA[d] = r.ra;
        if (issue && d >= 512 && d < 768) shadowB[d - 512] = r.ra;
        nextRefA = '1;
        nextRefB = '1;
        nextWefA = '1;
        nextWefB = '1;
        nRec++;
    endtask

    task automatic addIdle(input int testId, input int count);
        repeat (count) addInstr(testId, 1'b0, PASSA, 0, 0, 0, 1'b0);
    endtask

    task automatic checkValue(input int testId, input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error: time %0t signal %s got %h expected %h", $time, name, got, exp);
            errors++;
            testErrors[testId]++;
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus build and drive/compare loop
    // ------------------------------------------------------------
    initial begin
        int t;
        int j;
        instr = '0;
        branchCancel = 1'b0;
        rstN = 1'b0;
        {ioReadEfA, ioReadEfB, ioWriteEfA, ioWriteEfB} = '1;
        ioReadDataA = '0;
        ioReadDataB = '0;
        foreach (testErrors[i]) testErrors[i] = 0;

        addIdle(0, 4);
        addInstr(0, 1'b1, AND, 300, 301, 1000, 1'b0);
        for (int i = 0; i < 128; i++) begin
            addInstr(1, 1'b1, PASSA, 256 + (i & 3), 0, i, 1'b0);
            addInstr(1, 1'b1, PASSB, 0, 256 + (i & 3), 512 + i, 1'b0);
        end
        addIdle(1, 5);
        for (int i = 0; i < 200; i++) begin
            t = $unsigned($random(seed)) % 256;
            addInstr(2, 1'b1, aluOpT'(i & 7), $unsigned($random(seed)) % 128,
                     $unsigned($random(seed)) % 128, (t < 128) ? 128 + t : 512 + t, 1'b0);
        end
        addIdle(2, 5);
        nextRefA = 4'b1110;
        addInstr(3, 1'b1, PASSA, 256, 7, 5, 1'b0);
        nextRefB = 4'b1011;
        addInstr(3, 1'b1, PASSB, 9, 258, 517, 1'b0);
        addIdle(3, 5);
        addInstr(3, 1'b1, PASSA, 5, 5, 200, 1'b0);
        addInstr(3, 1'b1, PASSB, 5, 5, 201, 1'b0);
        addInstr(4, 1'b1, ADD, 10, 11, 257, 1'b0);
        addInstr(4, 1'b1, XOR, 12, 13, 770, 1'b0);
        nextWefA = 4'b1101;
        addInstr(4, 1'b1, PASSA, 14, 0, 257, 1'b0);
        nextWefB = 4'b1011;
        addInstr(4, 1'b1, PASSA, 15, 0, 770, 1'b0);
        addInstr(5, 1'b1, PASSA, 257, 0, 20, 1'b1);
        addInstr(5, 1'b1, PASSA, 21, 0, 259, 1'b1);
        addIdle(5, 5);
        addInstr(5, 1'b1, PASSA, 20, 0, 202, 1'b0);
        addIdle(5, 3);
        cycleLimit = nRec + 100;

        repeat (4) @(negedge clock);
        rstN = 1'b1;
        instr = recInstr[0];
        branchCancel = recCancel[0];
        for (int k = 0; k < nRec + 2; k++) begin
            @(negedge clock);
            instr = (k + 1 < nRec) ? recInstr[k + 1] : '0;
            branchCancel = (k + 1 < nRec) ? recCancel[k + 1] : 1'b0;
            if (k < nRec) begin
                ioReadEfA = recRefA[k];
                ioReadEfB = recRefB[k];
                ioWriteEfA = recWefA[k];
                ioWriteEfB = recWefB[k];
                ioReadDataA = recDataA[k];
                ioReadDataB = recDataB[k];
            end
            #2;
            if (k < nRec) begin
                checkValue(recTest[k], "ioReady", ioReady, recReady[k]);
                checkValue(recTest[k], "ioRdenA", ioRdenA, recRdenA[k]);
                checkValue(recTest[k], "ioRdenB", ioRdenB, recRdenB[k]);
            end
            j = k - 2;
            if (j >= 0) begin
                if (recCheckRes[j]) checkValue(recTest[j], "result", result, recRes[j]);
                checkValue(recTest[j], "ioWrenA", ioWrenA, recWrenA[j]);
                checkValue(recTest[j], "ioWrenB", ioWrenB, recWrenB[j]);
                if (recWrenA[j] != 0)
                    checkValue(recTest[j], "ioWriteDataA", ioWriteDataA, {4{recRes[j].ra}});
                if (recWrenB[j] != 0)
                    checkValue(recTest[j], "ioWriteDataB", ioWriteDataB, {4{recRes[j].ra}});
                if (j == nRec - 1 || recTest[j + 1] != recTest[j])
                    $display("Test %0d %s: %s, %0d errors", recTest[j], testName[recTest[j]],
                             (testErrors[recTest[j]] == 0) ? "ok" : "failed",
                             testErrors[recTest[j]]);
            end else begin
                // First cycles out of reset carry no write
                checkValue(0, "ioWrenA", ioWrenA, '0);
                checkValue(0, "ioWrenB", ioWrenB, '0);
            end
        end

        t = 0;
        foreach (testErrors[i]) if (testErrors[i] != 0) t++;
        $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 TEST_COUNT, t, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== list.f ====
datapathPkg.sv
ioPredication.sv
dataMemory.sv
operandFetch.sv
alu.sv
resultWriteback.sv
datapath.sv
datapathTb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = datapathTb
FILELIST = list.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
